// File: Makefile
TOP = osCheckerTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f osChecker.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: hdl/linkInfoCapture.sv
`timescale 1ns/1ps

module linkInfoCapture
    import osCheckPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      valid,
    input  osFields_t fields,
    output linkInfo_t linkInfo,
    output logic      fieldsChanged
);

    linkInfo_t nextInfo;

    always_comb
    begin
        nextInfo.rateId      = fields.rateId;
        nextInfo.linkNumber  = fields.linkNum;
        nextInfo.upconfigure = fields.upconfig;
    end

    // Compared against the previous set in the same cycle as the new one
    assign fieldsChanged = valid &&
                           ((nextInfo.rateId != linkInfo.rateId) ||
                            (nextInfo.upconfigure != linkInfo.upconfigure));

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            linkInfo <= '0;
        else if (valid)
            linkInfo <= nextInfo;
    end

endmodule

// File: hdl/osCheckPkg.sv
package osCheckPkg;

    // Substate codes as reported by the LTSSM
    typedef enum logic [4:0]
    {
        detectQuiet                 = 5'd0,
        detectActive                = 5'd1,
        pollingActive               = 5'd2,
        pollingConfiguration        = 5'd3,
        configLinkWidthStart        = 5'd4,
        configLinkWidthAccept       = 5'd5,
        configLanenumWait           = 5'd6,
        configLanenumAccept         = 5'd7,
        configComplete              = 5'd8,
        configIdle                  = 5'd9,
        linkL0                      = 5'd10,
        recoveryRcvrLock            = 5'd11,
        recoveryRcvrCfg             = 5'd12,
        recoverySpeed               = 5'd13,
        eqPhase0                    = 5'd14,
        eqPhase1                    = 5'd15,
        eqPhase2                    = 5'd16,
        eqPhase3                    = 5'd17,
        recoveryIdle                = 5'd18,
        recoverySpeedEieos          = 5'd19,
        recoveryWait                = 5'd20
    } ltssmSubstate_t;

    typedef enum logic
    {
        roleDownstream = 1'b0,
        roleUpstream   = 1'b1
    } deviceRole_t;

    // Training-sequence fields of one ordered set
    typedef struct packed
    {
        logic       isTs1Start;
        logic       isTs2Start;
        logic [7:0] linkNum;
        logic [7:0] laneNum;
        logic [7:0] rateId;
        logic       upconfig;
        logic       disableBit;
        logic [7:0] tsId;
        logic       isIdleData;
    } osFields_t;

    // Reported to the LTSSM from the last valid set
    typedef struct packed
    {
        logic [7:0] rateId;
        logic [7:0] linkNumber;
        logic       upconfigure;
    } linkInfo_t;

endpackage

// File: hdl/osCheck_macros.svh
`ifndef OS_CHECK_MACROS_SVH
`define OS_CHECK_MACROS_SVH

// Ordered-set width on the receive datapath
`define OS_WIDTH 128

// 8b/10b special symbols
`define SYM_COM 8'hBC
`define SYM_PAD 8'hF7

// Training-sequence identifiers
`define SYM_TS1ID 8'h4A
`define SYM_TS2ID 8'h45

// 128b/130b start symbols
`define SYM_G3TS1 8'h1E
`define SYM_G3TS2 8'h2D

// Low bytes that must be zero for idle data
`define IDLE_LOW_BYTES 8

// Byte and bit positions inside a training sequence
`define START_LSB   0
`define LINK_LSB    8
`define LANE_LSB    16
`define RATE_LSB    32
`define UPCFG_BIT   42
`define DISABLE_BIT 43
`define TSID_LSB    80

`endif

// File: hdl/osChecker.sv
`timescale 1ns/1ps

`include "osCheck_macros.svh"

module osChecker
    import osCheckPkg::*;
#(
    parameter deviceRole_t role = roleDownstream
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  logic [`OS_WIDTH-1:0] orderedSet,
    input  ltssmSubstate_t       substate,
    input  logic [7:0]           linkNumber,
    input  logic [7:0]           laneNumber,
    output logic                 countUp,
    output logic                 resetCounter,
    output linkInfo_t            linkInfo
);

    osFields_t fields;
    logic      fieldsChanged;
    logic      setMatches;
    logic      tracking;

    osFieldDecoder osFieldDecoder_inst (
        .orderedSet    (orderedSet),
        .fields        (fields)
    );

    tsMatchRules #(
        .role          (role)
    ) tsMatchRules_inst (
        .clk           (clk),
        .reset         (reset),
        .valid         (valid),
        .substate      (substate),
        .fields        (fields),
        .linkNumber    (linkNumber),
        .laneNumber    (laneNumber),
        .tracking      (tracking),
        .fieldsChanged (fieldsChanged),
        .setMatches    (setMatches)
    );

    osCountControl osCountControl_inst (
        .clk           (clk),
        .reset         (reset),
        .valid         (valid),
        .substate      (substate),
        .setMatches    (setMatches),
        .tracking      (tracking),
        .countUp       (countUp),
        .resetCounter  (resetCounter)
    );

    linkInfoCapture linkInfoCapture_inst (
        .clk           (clk),
        .reset         (reset),
        .valid         (valid),
        .fields        (fields),
        .linkInfo      (linkInfo),
        .fieldsChanged (fieldsChanged)
    );

endmodule

// File: hdl/osCountControl.sv
`timescale 1ns/1ps

module osCountControl
    import osCheckPkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           valid,
    input  ltssmSubstate_t substate,
    input  logic           setMatches,
    output logic           tracking,
    output logic           countUp,
    output logic           resetCounter
);

    logic           trackBit;
    ltssmSubstate_t trackSubstate;

    // Tracking only counts for the substate it was entered under
    assign tracking = trackBit && (substate == trackSubstate);

    assign countUp      = setMatches;
    assign resetCounter = tracking || countUp;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            trackBit      <= 1'b0;
            trackSubstate <= detectQuiet;
        end
        else if (valid)
        begin
            // A miss drops back to hunting, a hit starts or keeps tracking
            trackBit      <= setMatches;
            trackSubstate <= substate;
        end
    end

    countNeedsValid: assert property (
        @(posedge clk) disable iff (!reset) countUp |-> valid
    );

    countWithReset: assert property (
        @(posedge clk) disable iff (!reset) countUp |-> resetCounter
    );

endmodule

// File: hdl/osFieldDecoder.sv
`timescale 1ns/1ps

`include "osCheck_macros.svh"

module osFieldDecoder
    import osCheckPkg::*;
(
    input  logic [`OS_WIDTH-1:0] orderedSet,
    output osFields_t            fields
);

    logic [7:0] startSym;
    logic       comStart;

    assign startSym = orderedSet[`START_LSB +: 8];
    assign comStart = (startSym == `SYM_COM);

    always_comb
    begin
        // Gen1/2 sets start with COM, Gen3 sets carry their own start symbol
        fields.isTs1Start = comStart || (startSym == `SYM_G3TS1);
        fields.isTs2Start = comStart || (startSym == `SYM_G3TS2);

        fields.linkNum    = orderedSet[`LINK_LSB +: 8];
        fields.laneNum    = orderedSet[`LANE_LSB +: 8];
        fields.rateId     = orderedSet[`RATE_LSB +: 8];
        fields.upconfig   = orderedSet[`UPCFG_BIT];
        fields.disableBit = orderedSet[`DISABLE_BIT];
        fields.tsId       = orderedSet[`TSID_LSB +: 8];

        // Logical idle shows up as zero data in the low bytes
        fields.isIdleData = (orderedSet[`IDLE_LOW_BYTES*8-1:0] == '0);
    end

endmodule

// File: hdl/tsMatchRules.sv
`timescale 1ns/1ps

`include "osCheck_macros.svh"

module tsMatchRules
    import osCheckPkg::*;
#(
    parameter deviceRole_t role = roleDownstream
)
(
    input  logic           clk,
    input  logic           reset,
    input  logic           valid,
    input  ltssmSubstate_t substate,
    input  osFields_t      fields,
    input  logic [7:0]     linkNumber,
    input  logic [7:0]     laneNumber,
    input  logic           tracking,
    input  logic           fieldsChanged,
    output logic           setMatches
);

    logic       isTs1;
    logic       isTs2;
    logic       linkIsPad;
    logic       laneIsPad;
    logic       linkOk;
    logic       laneOk;
    logic       ruleOk;
    logic       learnLink;
    logic [7:0] learnedLink;

    assign isTs1     = fields.isTs1Start && (fields.tsId == `SYM_TS1ID);
    assign isTs2     = fields.isTs2Start && (fields.tsId == `SYM_TS2ID);
    assign linkIsPad = (fields.linkNum == `SYM_PAD);
    assign laneIsPad = (fields.laneNum == `SYM_PAD);
    assign linkOk    = (fields.linkNum == linkNumber);
    assign laneOk    = (fields.laneNum == laneNumber);

    always_comb
    begin
        case (substate)
            pollingActive:
                ruleOk = (isTs1 || isTs2) && linkIsPad && laneIsPad;
            pollingConfiguration:
                ruleOk = isTs2 && linkIsPad && laneIsPad;
            configLinkWidthStart:
                if (role == roleUpstream)
                    // Upstream picks up whatever link number the partner offers
                    ruleOk = isTs1 && !linkIsPad && laneIsPad &&
                             (!tracking || fields.linkNum == learnedLink);
                else
                    ruleOk = isTs1 && linkOk && laneIsPad;
            configLinkWidthAccept:
                ruleOk = (role == roleUpstream) && isTs1 && linkOk && !laneIsPad;
            configLanenumWait, configLanenumAccept:
                ruleOk = ((role == roleUpstream) ? isTs2 : isTs1) && linkOk && laneOk;
            configComplete:
                ruleOk = isTs2 && linkOk && laneOk && !(tracking && fieldsChanged);
            configIdle:
                ruleOk = fields.isIdleData;
            default:
                ruleOk = 1'b0;
        endcase
    end

    assign setMatches = valid && ruleOk;

    // First accepted set in LinkWidthStart fixes the link number
    assign learnLink = setMatches && !tracking && (role == roleUpstream) &&
                       (substate == configLinkWidthStart);

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            learnedLink <= '0;
        else if (learnLink)
            learnedLink <= fields.linkNum;
    end

    noMatchWithoutValid: assert property (
        @(posedge clk) disable iff (!reset) !valid |-> !setMatches
    );

endmodule

// File: osChecker.f
+incdir+hdl
hdl/osCheckPkg.sv
hdl/osFieldDecoder.sv
hdl/tsMatchRules.sv
hdl/osCountControl.sv
hdl/linkInfoCapture.sv
hdl/osChecker.sv
verification/osCheckerTb.sv

// File: verification/osCheckerTb.sv
`timescale 1ns/1ps

`include "osCheck_macros.svh"

module osCheckerTb
    import osCheckPkg::*;
();

    localparam int    CLK_HALF     = 50;
    localparam int    RESET_CYCLES = 5;
    localparam string PATTERN_FILE = "verification/osChecker_patterns.txt";

    // One cycle of stimulus and the responses expected for it
    typedef struct packed
    {
        ltssmSubstate_t       substate;
        logic                 valid;
        logic [`OS_WIDTH-1:0] orderedSet;
        logic [7:0]           linkNumber;
        logic [7:0]           laneNumber;
        logic                 expCountUp;
        logic                 expResetCounter;
        linkInfo_t            expLinkInfo;
    } patternLine_t;

    logic                 clk;
    logic                 reset;
    logic                 valid;
    logic [`OS_WIDTH-1:0] orderedSet;
    ltssmSubstate_t       substate;
    logic [7:0]           linkNumber;
    logic [7:0]           laneNumber;
    logic                 countUp;
    logic                 resetCounter;
    linkInfo_t            linkInfo;

    patternLine_t patterns[$];
    string        testNames[$];

    int countErrors = 0;
    int infoErrors  = 0;
    int otherErrors = 0;
    int cycleCount  = 0;
    int cycleLimit  = 0;

    osChecker #(
        .role          (roleDownstream)
    ) osChecker_inst (
        .clk           (clk),
        .reset         (reset),
        .valid         (valid),
        .orderedSet    (orderedSet),
        .substate      (substate),
        .linkNumber    (linkNumber),
        .laneNumber    (laneNumber),
        .countUp       (countUp),
        .resetCounter  (resetCounter),
        .linkInfo      (linkInfo)
    );

    always #(CLK_HALF) clk = ~clk;

    task automatic readPatterns();
        int                   fd;
        int                   fieldCount;
        string                line;
        string                name;
        logic [4:0]           subCode;
        logic                 vld;
        logic [`OS_WIDTH-1:0] setHex;
        logic [7:0]           linkHex;
        logic [7:0]           laneHex;
        logic                 cu;
        logic                 rc;
        logic [16:0]          infoHex;
        patternLine_t         entry;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the pattern file %s", PATTERN_FILE);
            otherErrors++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            // Skip blank lines and comments
            if (line.len() < 2 || line[0] == "#")
                continue;
            fieldCount = $sscanf(line, "%s %d %d %h %h %h %d %d %h", name, subCode, vld,
                                 setHex, linkHex, laneHex, cu, rc, infoHex);
            if (fieldCount != 9)
            begin
                $display("A pattern line could not be parsed: %s", line);
                otherErrors++;
                continue;
            end
            entry.substate        = ltssmSubstate_t'(subCode);
            entry.valid           = vld;
            entry.orderedSet      = setHex;
            entry.linkNumber      = linkHex;
            entry.laneNumber      = laneHex;
            entry.expCountUp      = cu;
            entry.expResetCounter = rc;
            entry.expLinkInfo     = infoHex;
            patterns.push_back(entry);
            testNames.push_back(name);
        end
        $fclose(fd);
    endtask

    task automatic applyPattern(input patternLine_t entry);
        valid      = entry.valid;
        orderedSet = entry.orderedSet;
        substate   = entry.substate;
        linkNumber = entry.linkNumber;
        laneNumber = entry.laneNumber;
    endtask

    task automatic checkCount(input string testName, input string signalName,
                              input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Fail %s: %s expected %0b actual %0b",
                     testName, signalName, expected, actual);
            countErrors++;
        end
    endtask

    task automatic checkLinkInfo(input string testName, input linkInfo_t expected,
                                 input linkInfo_t actual);
        if (actual !== expected)
        begin
            $display("Fail %s: linkInfo expected rate %h link %h up %b actual rate %h link %h up %b",
                     testName, expected.rateId, expected.linkNumber, expected.upconfigure,
                     actual.rateId, actual.linkNumber, actual.upconfigure);
            infoErrors++;
        end
    endtask

    task automatic finishRun();
        $display("Errors: count outputs %0d, linkInfo %0d, other %0d over %0d patterns",
                 countErrors, infoErrors, otherErrors, patterns.size());
        if (countErrors + infoErrors + otherErrors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    endtask

    // Limit follows from the number of pattern lines
    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            otherErrors++;
            finishRun();
        end
    end

    initial
    begin
        clk        = 1'b0;
        reset      = 1'b0;
        valid      = 1'b0;
        orderedSet = '0;
        substate   = detectQuiet;
        linkNumber = '0;
        laneNumber = '0;

        readPatterns();
        cycleLimit = patterns.size() * 2 + 20;
        if (patterns.size() == 0)
        begin
            $display("No pattern lines were read");
            otherErrors++;
        end

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b1;

        foreach (patterns[i])
        begin
            applyPattern(patterns[i]);
            // Count outputs are combinational, sample them mid low phase
            #(CLK_HALF / 2);
            checkCount(testNames[i], "countUp", patterns[i].expCountUp, countUp);
            checkCount(testNames[i], "resetCounter", patterns[i].expResetCounter,
                       resetCounter);
            @(negedge clk);
            checkLinkInfo(testNames[i], patterns[i].expLinkInfo, linkInfo);
        end

        valid = 1'b0;
        finishRun();
    end

endmodule

// File: verification/osChecker_patterns.txt
# Columns: name substate(dec) valid orderedSet(hex) linkNumber(hex) laneNumber(hex)
#          countUp resetCounter linkInfo(hex, after the clock edge ending the cycle)

# Polling.Active with PAD link and lane
pollTs1First   2 1 00000000004a00000000000200f7f7bc 00 00 1 1 005ee
pollTs1Second  2 1 00000000004a00000000000200f7f7bc 00 00 1 1 005ee
pollTs1Third   2 1 00000000004a00000000000200f7f7bc 00 00 1 1 005ee
pollBadLink    2 1 00000000004a00000000000200f701bc 00 00 0 1 00402
pollAfterMiss  2 0 00000000004a00000000000200f7f7bc 00 00 0 0 00402
pollTs2Rehunt  2 1 00000000004500000000000200f7f7bc 00 00 1 1 005ee

# Cycles without valid hold tracking
gapFirst       2 0 00000000004a00000000000200f7f7bc 00 00 0 1 005ee
gapSecond      2 0 00000000004a00000000000200f7f7bc 00 00 0 1 005ee
gapResume      2 1 00000000004a00000000000200f7f7bc 00 00 1 1 005ee

# Config.LanenumWait, downstream expects TS1 with link 01 lane 03
laneWrong      6 1 00000000004a000000000002000501bc 01 03 0 0 00402
laneMatch      6 1 00000000004a000000000002000301bc 01 03 1 1 00402
laneTrack      6 1 00000000004a000000000002000301bc 01 03 1 1 00402
laneTs2Reject  6 1 000000000045000000000002000301bc 01 03 0 1 00402
laneIdleGap    6 0 00000000004a000000000002000301bc 01 03 0 0 00402

# Config.Complete, rate id and upconfigure must stay constant
cplFirst       8 1 000000000045000000000002000301bc 01 03 1 1 00402
cplSecond      8 1 000000000045000000000002000301bc 01 03 1 1 00402
cplRateChange  8 1 000000000045000000000003000301bc 01 03 0 1 00602
cplRehunt      8 1 000000000045000000000003000301bc 01 03 1 1 00602
cplUpcfgChange 8 1 000000000045000000000403000301bc 01 03 0 1 00603

# Config.Idle and unchecked substates
idleFirst      9 1 12345678abcdef010000000000000000 00 00 1 1 00000
idleSecond     9 1 00000000000000000000000000000000 00 00 1 1 00000
idleBadData    9 1 00000000004a00000000000200f7f7bc 00 00 0 1 005ee
idleRehunt     9 1 00000000000000000000000000000000 00 00 1 1 00000
unchkL0Idle   10 1 00000000000000000000000000000000 00 00 0 0 00000
unchkL0Ts1    10 1 00000000004a00000000000200f7f7bc 00 00 0 0 005ee
unchkRecovery 11 1 00000000004a00000000000200f7f7bc 00 00 0 0 005ee
unchkPollGap   2 0 00000000004a00000000000200f7f7bc 00 00 0 0 005ee

# linkInfo follows each valid set
infoUpcfg     10 1 00000000004a00000000041f00f72abc 00 00 0 0 03e55
infoHold      10 0 00000000000000000000000000000000 00 00 0 0 03e55
infoWide      10 1 00000000004a00000000008000f7ffbc 00 00 0 0 101fe
